// File: hw/controller_pkg.sv
// ----------------------------------------
// Controller package
// Bus, drive and mode types plus SCL timing
// ----------------------------------------
package controller_pkg;

  // SCL timing, in clock cycles
  localparam int unsigned SclHalfCycles = 4;
  localparam int unsigned AddrBits = 8;

  // START + 8 bits (low and high half each) + STOP (low and high)
  localparam int unsigned XferCycles = (1 + 2 * AddrBits + 2) * SclHalfCycles;

  typedef logic [AddrBits-1:0] bus_addr_t;
  typedef logic [$clog2(SclHalfCycles)-1:0] half_cnt_t;
  typedef logic [$clog2(AddrBits)-1:0] bit_cnt_t;
  typedef logic [$clog2(XferCycles+1)-1:0] xfer_cnt_t;

  typedef enum logic {
    MODE_STANDBY = 1'b0,
    MODE_ACTIVE  = 1'b1
  } ctrl_mode_t;

  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic start;
    logic rstart;
    logic stop;
    logic in_frame;
  } bus_state_t;

  // Open drain, 1 releases the line
  typedef struct packed {
    logic scl;
    logic sda;
  } phy_drive_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    BIT_LOW,
    BIT_HIGH,
    STOP_LOW,
    STOP_HIGH
  } active_state_t;

  localparam bus_state_t BusIdle = '{scl: 1'b1, sda: 1'b1, default: 1'b0};

endpackage

// File: hw/bus_monitor.sv
// ----------------------------------------
// Bus state monitor
// Synchronizes SCL/SDA and flags START,
// repeated START and STOP conditions
// ----------------------------------------
module bus_monitor
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_state_t state_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_s;
  logic       sda_s;
  logic       scl_high;
  logic       sda_fall;
  logic       sda_rise;
  bus_state_t state_q;

  // Two-stage synchronizers, idle bus is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
    end
  end

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // state_q holds the previous synchronized sample
  assign scl_high = state_q.scl & scl_s;
  assign sda_fall = state_q.sda & ~sda_s;
  assign sda_rise = ~state_q.sda & sda_s;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= BusIdle;
    end else begin
      state_q.scl      <= scl_s;
      state_q.sda      <= sda_s;
      state_q.scl_rise <= ~state_q.scl & scl_s;
      state_q.start    <= scl_high & sda_fall & ~state_q.in_frame;
      state_q.rstart   <= scl_high & sda_fall & state_q.in_frame;
      state_q.stop     <= scl_high & sda_rise;

      // Frame opens on any START, closes on STOP
      if (scl_high & sda_fall) begin
        state_q.in_frame <= 1'b1;
      end else if (scl_high & sda_rise) begin
        state_q.in_frame <= 1'b0;
      end
    end
  end

  assign state_o = state_q;

endmodule

// File: hw/phy_arbiter.sv
// ----------------------------------------
// PHY arbiter
// Grants the pins to one peer and defers
// mode changes until the bus is free
// ----------------------------------------
module phy_arbiter
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_we_i,
  input  ctrl_mode_t cfg_mode_i,
  input  bus_state_t bus_i,
  input  logic       busy_i,
  input  phy_drive_t active_drive_i,
  input  phy_drive_t standby_drive_i,
  output bus_state_t active_bus_o,
  output bus_state_t standby_bus_o,
  output logic       active_grant_o,
  output logic       scl_o,
  output logic       sda_o
);

  ctrl_mode_t mode_q;
  ctrl_mode_t pend_mode_q;
  ctrl_mode_t next_mode;
  logic       pend_q;
  logic       bus_free;
  logic       grant;

  assign bus_free  = ~bus_i.in_frame & ~busy_i;
  // A fresh write overrides an older pending one
  assign next_mode = cfg_we_i ? cfg_mode_i : pend_mode_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_q <= MODE_STANDBY;
      pend_q <= 1'b0;
    end else if ((cfg_we_i | pend_q) & bus_free) begin
      mode_q <= next_mode;
      pend_q <= 1'b0;
    end else if (cfg_we_i) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_we_i) begin
      pend_mode_q <= cfg_mode_i;
    end
  end

  assign grant          = (mode_q == MODE_ACTIVE);
  assign active_grant_o = grant;

  // Unselected peer sees an idle bus
  always_comb begin
    active_bus_o  = BusIdle;
    standby_bus_o = BusIdle;
    if (grant) begin
      active_bus_o = bus_i;
      scl_o        = active_drive_i.scl;
      sda_o        = active_drive_i.sda;
    end else begin
      standby_bus_o = bus_i;
      scl_o         = standby_drive_i.scl;
      sda_o         = standby_drive_i.sda;
    end
  end

endmodule

// File: hw/active_controller.sv
// ----------------------------------------
// Active controller
// Drives START, one address byte and STOP
// ----------------------------------------
module active_controller
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       grant_i,
  input  logic       cmd_valid_i,
  input  bus_addr_t  cmd_addr_i,
  input  bus_state_t bus_i,
  output phy_drive_t drive_o,
  output logic       busy_o
);

  active_state_t state_q;
  active_state_t state_d;
  half_cnt_t     half_cnt_q;
  bit_cnt_t      bit_cnt_q;
  xfer_cnt_t     xfer_left_q;
  bus_addr_t     shift_q;
  logic          accept;
  logic          half_end;
  logic          last_bit;
  logic          bit_done;

  // Refuse while someone else's frame is still on the bus
  assign accept   = cmd_valid_i & grant_i & (state_q == IDLE) & ~bus_i.in_frame;
  assign half_end = (half_cnt_q == half_cnt_t'(SclHalfCycles - 1));
  assign last_bit = (bit_cnt_q == bit_cnt_t'(AddrBits - 1));
  assign bit_done = (state_q == BIT_HIGH) & half_end;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (accept) state_d = START;
      START:     if (half_end) state_d = BIT_LOW;
      BIT_LOW:   if (half_end) state_d = BIT_HIGH;
      BIT_HIGH:  if (half_end) state_d = last_bit ? STOP_LOW : BIT_LOW;
      STOP_LOW:  if (half_end) state_d = STOP_HIGH;
      STOP_HIGH: if (half_end) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      half_cnt_q  <= '0;
      bit_cnt_q   <= '0;
      xfer_left_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        half_cnt_q  <= '0;
        bit_cnt_q   <= '0;
        xfer_left_q <= xfer_cnt_t'(XferCycles);
      end else if (state_q != IDLE) begin
        half_cnt_q  <= half_end ? '0 : half_cnt_q + 1'b1;
        xfer_left_q <= xfer_left_q - 1'b1;
        if (bit_done) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end
    end
  end

  // MSB first, next bit lands as SCL falls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= cmd_addr_i;
    end else if (bit_done) begin
      shift_q <= {shift_q[AddrBits-2:0], 1'b0};
    end
  end

  always_comb begin
    drive_o = '{scl: 1'b1, sda: 1'b1};
    case (state_q)
      START: drive_o.sda = 1'b0;
      BIT_LOW: begin
        drive_o.scl = 1'b0;
        drive_o.sda = shift_q[AddrBits-1];
      end
      BIT_HIGH: drive_o.sda = shift_q[AddrBits-1];
      STOP_LOW: begin
        drive_o.scl = 1'b0;
        drive_o.sda = 1'b0;
      end
      STOP_HIGH: drive_o.sda = 1'b0;
      default: drive_o = '{scl: 1'b1, sda: 1'b1};
    endcase
  end

  // Runs down over the whole 19 half periods
  assign busy_o = (xfer_left_q != '0);

endmodule

// File: hw/target_addr_capture.sv
// ----------------------------------------
// Target address capture
// Reports the first byte after each START
// ----------------------------------------
module target_addr_capture
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  bus_state_t bus_i,
  output phy_drive_t drive_o,
  output bus_addr_t  addr_o,
  output logic       addr_valid_o
);

  bus_addr_t shift_q;
  bus_addr_t addr_q;
  bit_cnt_t  bit_cnt_q;
  logic      armed_q;
  logic      valid_q;
  logic      sample;
  logic      last_bit;

  assign sample   = armed_q & bus_i.scl_rise;
  assign last_bit = (bit_cnt_q == bit_cnt_t'(AddrBits - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      armed_q   <= 1'b0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
      addr_q    <= '0;
    end else begin
      valid_q <= 1'b0;
      if (bus_i.start | bus_i.rstart) begin
        armed_q   <= 1'b1;
        bit_cnt_q <= '0;
      end else if (bus_i.stop) begin
        armed_q <= 1'b0;
      end else if (sample) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (last_bit) begin
          // Rest of the frame is ignored
          armed_q <= 1'b0;
          valid_q <= 1'b1;
          addr_q  <= {shift_q[AddrBits-2:0], bus_i.sda};
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[AddrBits-2:0], bus_i.sda};
    end
  end

  // No ACK, lines stay released
  assign drive_o      = '{scl: 1'b1, sda: 1'b1};
  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;

endmodule

// File: hw/controller.sv
// ----------------------------------------
// Controller top
// Bus monitor, PHY arbiter, active peer
// and standby address capture
// ----------------------------------------
module controller
  import controller_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       cfg_we_i,
  input  ctrl_mode_t cfg_mode_i,
  input  logic       cmd_valid_i,
  input  bus_addr_t  cmd_addr_i,
  output logic       scl_o,
  output logic       sda_o,
  output logic       bus_start_o,
  output logic       bus_rstart_o,
  output logic       bus_stop_o,
  output bus_addr_t  bus_addr_o,
  output logic       bus_addr_valid_o,
  output logic       xfer_in_progress_o
);

  bus_state_t bus;
  bus_state_t active_bus;
  bus_state_t standby_bus;
  phy_drive_t active_drive;
  phy_drive_t standby_drive;
  logic       active_grant;

  bus_monitor xbus_monitor (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .state_o (bus)
  );

  phy_arbiter xphy_arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cfg_we_i        (cfg_we_i),
    .cfg_mode_i      (cfg_mode_i),
    .bus_i           (bus),
    .busy_i          (xfer_in_progress_o),
    .active_drive_i  (active_drive),
    .standby_drive_i (standby_drive),
    .active_bus_o    (active_bus),
    .standby_bus_o   (standby_bus),
    .active_grant_o  (active_grant),
    .scl_o           (scl_o),
    .sda_o           (sda_o)
  );

  active_controller xactive_controller (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .grant_i     (active_grant),
    .cmd_valid_i (cmd_valid_i),
    .cmd_addr_i  (cmd_addr_i),
    .bus_i       (active_bus),
    .drive_o     (active_drive),
    .busy_o      (xfer_in_progress_o)
  );

  target_addr_capture xtarget_addr_capture (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_i        (standby_bus),
    .drive_o      (standby_drive),
    .addr_o       (bus_addr_o),
    .addr_valid_o (bus_addr_valid_o)
  );

  // Conditions as seen on the pins, whichever peer owns them
  assign bus_start_o  = bus.start;
  assign bus_rstart_o = bus.rstart;
  assign bus_stop_o   = bus.stop;

endmodule

// File: sim/controller_properties.sv
// ----------------------------------------
// Controller properties
// Pin release, capture pulse and bus
// condition assertions
// ----------------------------------------
module controller_properties (
  input logic clk_i,
  input logic reset_i,
  input logic scl_o,
  input logic sda_o,
  input logic xfer_in_progress_o,
  input logic bus_addr_valid_o,
  input logic bus_start_o,
  input logic bus_rstart_o,
  input logic bus_stop_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Lines released outside a transfer
  pins_released: assert property (@(posedge clk_i) disable iff (reset_i)
    !xfer_in_progress_o |-> (scl_o && sda_o))
    else $error("SCL or SDA driven low with no transfer in progress");

  addr_valid_single: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_addr_valid_o |=> !bus_addr_valid_o)
    else $error("address valid held for two cycles");

  conditions_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({bus_start_o, bus_rstart_o, bus_stop_o}))
    else $error("more than one bus condition flagged in a cycle");

endmodule

bind controller controller_properties properties (.*);

// File: sim/tb_controller.sv
// ----------------------------------------
// Controller testbench
// Open-drain bus model, frames and checks
// ----------------------------------------
module tb_controller
  import controller_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // The full run is about 700 cycles
  localparam int TimeoutCycles = 4000;
  localparam int TbHalfCycles = 6;

  logic       clk_i = 1'b0;
  logic       reset_i = 1'b1;
  logic       tb_scl = 1'b1;
  logic       tb_sda = 1'b1;
  logic       cfg_we_i = 1'b0;
  ctrl_mode_t cfg_mode_i = MODE_STANDBY;
  logic       cmd_valid_i = 1'b0;
  bus_addr_t  cmd_addr_i = '0;
  logic       scl_o;
  logic       sda_o;
  logic       bus_start_o;
  logic       bus_rstart_o;
  logic       bus_stop_o;
  bus_addr_t  bus_addr_o;
  logic       bus_addr_valid_o;
  logic       xfer_in_progress_o;

  // Open-drain wired AND where either side can pull a line low
  wire scl_i = scl_o & tb_scl;
  wire sda_i = sda_o & tb_sda;

  int              cycles;
  int              n_start;
  int              n_rstart;
  int              n_stop;
  int              n_xfer;
  int              n_pin_low;
  int              start_cyc;
  int              stop_cyc;
  int              busy_len;
  int              last_busy_len;
  int              rx_count;
  int              last_rx_count;
  logic [AddrBits:0] rx_bits;
  logic [AddrBits:0] last_rx_bits;
  logic            prev_scl = 1'b1;
  logic            prev_busy = 1'b0;
  bus_addr_t       captures[$];

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  controller dut (.*);

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // Counts conditions, captures and transfer bits on the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (bus_start_o) begin
        n_start++;
        start_cyc = cycles;
      end
      if (bus_rstart_o) n_rstart++;
      if (bus_stop_o) begin
        n_stop++;
        stop_cyc = cycles;
      end
      if (bus_addr_valid_o) captures.push_back(bus_addr_o);
      if (!scl_o || !sda_o) n_pin_low++;
      if (xfer_in_progress_o) begin
        if (!prev_busy) begin
          n_xfer++;
          busy_len = 0;
          rx_count = 0;
        end
        busy_len++;
        if (scl_o && !prev_scl) begin
          rx_bits = {rx_bits[AddrBits-1:0], sda_o};
          rx_count++;
        end
      end else if (prev_busy) begin
        last_busy_len = busy_len;
        last_rx_bits  = rx_bits;
        last_rx_count = rx_count;
      end
      prev_scl  = scl_o;
      prev_busy = xfer_in_progress_o;
    end
  end

  // Expected SDA at each SCL rise of a transfer
  // Address MSB first and the STOP low level last
  function automatic logic [AddrBits:0] expected_bits(bus_addr_t addr);
    logic [AddrBits:0] bits;
    bus_addr_t         rest;
    bits = '0;
    rest = addr;
    repeat (AddrBits) begin
      bits = {bits[AddrBits-1:0], rest[AddrBits-1]};
      rest = rest << 1;
    end
    bits = {bits[AddrBits-1:0], 1'b0};
    return bits;
  endfunction

  task automatic check_value(string what, int got, int exp);
    assert (got == exp) else begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_for_stop(int base);
    while (n_stop == base) @(posedge clk_i);
  endtask

  task automatic drive_half(logic scl, logic sda);
    tb_scl <= scl;
    tb_sda <= sda;
    repeat (TbHalfCycles) @(posedge clk_i);
  endtask

  task automatic drive_byte(bus_addr_t b);
    bus_addr_t rest;
    rest = b;
    repeat (AddrBits) begin
      drive_half(1'b0, rest[AddrBits-1]);
      drive_half(1'b1, rest[AddrBits-1]);
      rest = rest << 1;
    end
  endtask

  task automatic drive_rstart();
    drive_half(1'b0, 1'b1);
    drive_half(1'b1, 1'b1);
    drive_half(1'b1, 1'b0);
  endtask

  task automatic drive_stop();
    drive_half(1'b0, 1'b0);
    drive_half(1'b1, 1'b0);
    drive_half(1'b1, 1'b1);
  endtask

  task automatic write_mode(ctrl_mode_t mode);
    cfg_we_i   <= 1'b1;
    cfg_mode_i <= mode;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic send_command(bus_addr_t addr);
    cmd_valid_i <= 1'b1;
    cmd_addr_i  <= addr;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic standby_frame(bus_addr_t a, bus_addr_t b, bit rstart);
    int cap0 = captures.size();
    int start0 = n_start;
    int rstart0 = n_rstart;
    int stop0 = n_stop;
    int low0 = n_pin_low;
    int xfer0 = n_xfer;
    // START
    drive_half(1'b1, 1'b0);
    // Refused while the standby peer owns the pins
    send_command(a);
    drive_byte(a);
    if (rstart) begin
      drive_rstart();
      drive_byte(b);
    end
    drive_stop();
    wait_for_stop(stop0);
    check_value("captures", captures.size() - cap0, 1 + int'(rstart));
    check_value("first capture", int'(captures[cap0]), int'(a));
    if (rstart) check_value("second capture", int'(captures[cap0 + 1]), int'(b));
    check_value("START count", n_start - start0, 1);
    check_value("repeated START count", n_rstart - rstart0, int'(rstart));
    check_value("STOP count", n_stop - stop0, 1);
    check_value("pins pulled low in standby", n_pin_low - low0, 0);
    check_value("transfers in standby", n_xfer - xfer0, 0);
  endtask

  task automatic active_transfer(bus_addr_t addr, bit extra);
    int xfer0 = n_xfer;
    int start0 = n_start;
    int rstart0 = n_rstart;
    int stop0 = n_stop;
    send_command(addr);
    if (extra) begin
      // Both arrive while busy
      wait_cycles(10);
      send_command(~addr);
      wait_cycles(20);
      send_command(addr ^ 8'h5a);
    end
    wait_for_stop(stop0);
    check_value("transfers", n_xfer - xfer0, 1);
    check_value("busy cycles", last_busy_len, XferCycles);
    check_value("SCL rises", last_rx_count, AddrBits + 1);
    check_value("SDA bits", int'(last_rx_bits), int'(expected_bits(addr)));
    check_value("START count", n_start - start0, 1);
    check_value("repeated START count", n_rstart - rstart0, 0);
    check_value("STOP count", n_stop - stop0, 1);
    check_value("START before STOP", int'(start_cyc < stop_cyc), 1);
  endtask

  initial begin
    bus_addr_t addr;
    int        xfer0;
    int        stop0;
    int        cap0;
    void'($urandom(73));
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("scl_o after reset", int'(scl_o), 1);
    check_value("sda_o after reset", int'(sda_o), 1);
    check_value("status after reset", int'({bus_start_o, bus_rstart_o, bus_stop_o,
                bus_addr_valid_o, xfer_in_progress_o}), 0);
    @(posedge clk_i);

    standby_frame(bus_addr_t'($urandom), 8'h00, 1'b0);
    xfer0 = n_xfer;
    send_command(bus_addr_t'($urandom));
    wait_cycles(10);
    check_value("transfers after standby command", n_xfer - xfer0, 0);
    standby_frame(bus_addr_t'($urandom), bus_addr_t'($urandom), 1'b1);

    // Mode write inside a frame waits for its STOP
    addr  = bus_addr_t'($urandom);
    xfer0 = n_xfer;
    stop0 = n_stop;
    cap0  = captures.size();
    drive_half(1'b1, 1'b0);
    write_mode(MODE_ACTIVE);
    drive_byte(addr);
    send_command(addr);
    drive_stop();
    wait_for_stop(stop0);
    check_value("captures during deferred write", captures.size() - cap0, 1);
    check_value("transfers before STOP", n_xfer - xfer0, 0);
    // Commit on the first free cycle and grant one cycle later
    wait_cycles(2);
    active_transfer(bus_addr_t'($urandom), 1'b0);
    active_transfer(bus_addr_t'($urandom), 1'b1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: controller.f
hw/controller_pkg.sv
hw/bus_monitor.sv
hw/phy_arbiter.sv
hw/active_controller.sv
hw/target_addr_capture.sv
hw/controller.sv
sim/controller_properties.sv
sim/tb_controller.sv

// File: run_sim.sh
#!/bin/sh
# Build the controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_controller \
  -f controller.f -o sim_controller
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_controller 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
